// File: emesh_pkg.sv
// mesh packet format
`default_nettype none

package emesh_pkg;

   //####################################################################
   // packet layout
   //####################################################################
   localparam int PW        = 104;          // packet width
   localparam int PKT_BYTES = 13;           // bytes per packet on the pins
   localparam int BCW       = 4;            // byte counter width

   localparam int WRITE_BIT    = 0;
   localparam int DATAMODE_LSB = 1;         // 2 bits
   localparam int CTRLMODE_LSB = 3;         // 4 bits, bit 7 reserved
   localparam int DSTADDR_LSB  = 8;         // 32 bits
   localparam int DATA_LSB     = 40;        // 32 bits
   localparam int SRCADDR_LSB  = 72;        // 32 bits

   // upper 12 bits of dstaddr, packet bits 39:28
   localparam int LINK_LSB = DSTADDR_LSB + 20;

   //####################################################################
   // link id and remap
   //####################################################################
   // dstaddr[31:20] equal to this stays on chip
   localparam logic [11:0] LINK_ID = 12'h810;

   // mask bit 1 takes the pattern bit
   localparam logic [11:0] REMAP_MASK    = 12'hFC0;
   localparam logic [11:0] REMAP_PATTERN = 12'h3C0;

endpackage

`default_nettype wire

// File: elink_regmap_pkg.sv
// tx register map
`default_nettype none

package elink_regmap_pkg;

   localparam int RFAW = 6;                 // word address width

   // word addresses, mi_addr[7:2]
   typedef enum logic [RFAW-1:0] {
      E_VERSION   = 6'd0,
      ETX_CFG     = 6'd1,
      ETX_STATUS  = 6'd2,
      ETX_GPIO    = 6'd3,
      ETX_MONITOR = 6'd4,
      ETX_PACKET  = 6'd5
   } etx_reg_e;

   //####################################################################
   // config bits
   //####################################################################
   localparam int CFG_TX_ENABLE = 0;
   localparam int CFG_MMU       = 1;        // stored only
   localparam int CFG_REMAP     = 2;        // 2 bits, 01 = remap on
   localparam int CFG_CTRLMODE  = 4;        // 4 bits
   localparam int CFG_BYPASS    = 8;
   localparam int CFG_GPIO      = 9;        // 2 bits, 01 = gpio mode
   localparam int CFG_BURST     = 11;       // stored only
   localparam int CFG_W         = CFG_BURST + 1;

   // status bits, the rest read zero
   localparam int ST_SENT     = 0;          // pulse, packet done on pins
   localparam int ST_GPIO     = 1;          // gpio mode active
   localparam int ST_ETX_WAIT = 6;
   localparam int ST_TXI_WAIT = 7;

   localparam logic [15:0] DEFAULT_VERSION = 16'h0104;

endpackage

`default_nettype wire

// File: etx_cfg_if.sv
// tx static configuration
`timescale 1ns/1ps
`default_nettype none

interface etx_cfg_if;

   logic       tx_enable;
   logic       remap_enable;
   logic [3:0] ctrlmode;           // ctrlmode override value
   logic       ctrlmode_bypass;
   logic       gpio_enable;
   logic [8:0] gpio_data;          // frame bit 8, data 7:0

   // register file side
   modport src (output tx_enable, remap_enable, ctrlmode, ctrlmode_bypass,
                       gpio_enable, gpio_data);

   // packet blocks only look
   modport dst (input  tx_enable, remap_enable, ctrlmode, ctrlmode_bypass,
                       gpio_enable, gpio_data);

endinterface

`default_nettype wire

// File: etx_cfg.sv
// tx config and status registers
`timescale 1ns/1ps
`default_nettype none

module etx_cfg (
   input  logic                             clk,
   input  logic                             nreset,
   // memory interface
   input  logic                             mi_en,
   input  logic                             mi_we,
   input  logic [elink_regmap_pkg::RFAW+1:0] mi_addr,   // byte address
   input  logic [31:0]                      mi_din,
   output logic [31:0]                      mi_dout,
   // packet port, watched only
   input  logic                             etx_access,
   input  logic                             etx_wait,
   input  logic [emesh_pkg::PW-1:0]         etx_packet,
   input  logic [15:0]                      tx_status,
   etx_cfg_if.src                           cfg
);
   import emesh_pkg::*;
   import elink_regmap_pkg::*;

   logic [CFG_W-1:0] cfg_reg;
   logic [8:0]       gpio_reg;
   logic [15:0]      version_reg;
   logic [15:0]      status_reg;
   logic [31:0]      monitor_reg;
   logic [31:0]      packet_reg;

   etx_reg_e reg_addr;
   logic     reg_write;
   logic     reg_read;
   logic     pkt_count;                     // accepted and leaving the chip

   //####################################################################
   // decode
   //####################################################################
   assign reg_addr  = etx_reg_e'(mi_addr[RFAW+1:2]);  // low 2 bits ignored
   assign reg_write = mi_en & mi_we;
   assign reg_read  = mi_en & ~mi_we;

   // local packets never reach the pins' counters
   assign pkt_count = etx_access & ~etx_wait &
                      (etx_packet[LINK_LSB +: 12] != LINK_ID);

   //####################################################################
   // registers
   //####################################################################
   always_ff @(posedge clk) begin
      if (!nreset) begin
         cfg_reg     <= '0;
         gpio_reg    <= '0;
         version_reg <= DEFAULT_VERSION;
         status_reg  <= '0;
         monitor_reg <= '0;
         packet_reg  <= '0;
      end else begin
         if (reg_write && reg_addr == ETX_CFG)
            cfg_reg <= mi_din[CFG_W-1:0];
         if (reg_write && reg_addr == ETX_GPIO)
            gpio_reg <= mi_din[8:0];
         if (reg_write && reg_addr == E_VERSION)
            version_reg <= mi_din[15:0];

         // sticky, write replaces
         if (reg_write && reg_addr == ETX_STATUS)
            status_reg <= mi_din[15:0];
         else
            status_reg <= status_reg | tx_status;

         // transaction monitor
         if (reg_write && reg_addr == ETX_MONITOR)
            monitor_reg <= mi_din;
         else if (pkt_count)
            monitor_reg <= monitor_reg + 32'd1;

         // dstaddr sample, before remap
         if (pkt_count)
            packet_reg <= etx_packet[DSTADDR_LSB +: 32];
      end
   end

   //####################################################################
   // readback, one cycle latency
   //####################################################################
   always_ff @(posedge clk) begin
      if (!nreset) begin
         mi_dout <= '0;
      end else if (reg_read) begin
         case (reg_addr)
            E_VERSION:   mi_dout <= {16'b0, version_reg};
            ETX_CFG:     mi_dout <= {{(32-CFG_W){1'b0}}, cfg_reg};
            ETX_STATUS:  mi_dout <= {16'b0, status_reg};
            ETX_GPIO:    mi_dout <= {23'b0, gpio_reg};
            ETX_MONITOR: mi_dout <= monitor_reg;
            ETX_PACKET:  mi_dout <= packet_reg;
            default:     mi_dout <= 32'd0;           // unmapped
         endcase
      end
   end

   //####################################################################
   // config fields out
   //####################################################################
   assign cfg.tx_enable       = cfg_reg[CFG_TX_ENABLE];
   assign cfg.remap_enable    = (cfg_reg[CFG_REMAP +: 2] == 2'b01);
   assign cfg.ctrlmode        = cfg_reg[CFG_CTRLMODE +: 4];
   assign cfg.ctrlmode_bypass = cfg_reg[CFG_BYPASS];
   assign cfg.gpio_enable     = (cfg_reg[CFG_GPIO +: 2] == 2'b01);
   assign cfg.gpio_data       = gpio_reg;

endmodule

`default_nettype wire

// File: etx_remap.sv
// packet hold, ctrlmode override and remap
`timescale 1ns/1ps
`default_nettype none

module etx_remap (
   input  logic                     clk,
   input  logic                     nreset,
   input  logic                     etx_access,
   input  logic [emesh_pkg::PW-1:0] etx_packet,
   output logic                     etx_wait,
   etx_cfg_if.dst                   cfg,
   output logic                     pkt_valid,
   output logic [emesh_pkg::PW-1:0] pkt,
   input  logic                     pkt_take      // io empties the stage
);
   import emesh_pkg::*;

   logic          accept;
   logic [PW-1:0] pkt_next;
   logic [11:0]   addr_hi;                        // dstaddr[31:20]

   // full stage stalls unless io takes it this cycle
   assign etx_wait = ~cfg.tx_enable | cfg.gpio_enable | (pkt_valid & ~pkt_take);
   assign accept   = etx_access & ~etx_wait;

   assign addr_hi = etx_packet[LINK_LSB +: 12];

   always_comb begin
      pkt_next = etx_packet;
      if (cfg.ctrlmode_bypass)
         pkt_next[CTRLMODE_LSB +: 4] = cfg.ctrlmode;
      // pattern bits where the mask is set
      if (cfg.remap_enable)
         pkt_next[LINK_LSB +: 12] = (addr_hi & ~REMAP_MASK) | (REMAP_PATTERN & REMAP_MASK);
   end

   always_ff @(posedge clk) begin
      if (!nreset)
         pkt_valid <= 1'b0;
      else if (accept)
         pkt_valid <= 1'b1;                       // refill on take
      else if (pkt_take)
         pkt_valid <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (accept)
         pkt <= pkt_next;
   end

endmodule

`default_nettype wire

// File: etx_io.sv
// tx pin driver
`timescale 1ns/1ps
`default_nettype none

module etx_io (
   input  logic                     clk,
   input  logic                     nreset,
   etx_cfg_if.dst                   cfg,
   input  logic                     pkt_valid,
   input  logic [emesh_pkg::PW-1:0] pkt,
   output logic                     pkt_take,
   input  logic                     txi_wait,     // far end back-pressure
   input  logic                     etx_wait,
   output logic                     txo_frame,
   output logic [7:0]               txo_data,
   output logic [15:0]              tx_status
);
   import emesh_pkg::*;
   import elink_regmap_pkg::*;

   typedef enum logic [1:0] {
      IO_IDLE,
      IO_SEND,
      IO_GPIO
   } etx_io_state_e;

   etx_io_state_e state;
   logic [PW-1:0] shift_reg;                      // bytes not yet on pins
   logic [BCW-1:0] byte_cnt;                      // byte now on pins
   logic          last_byte;

   assign last_byte = (byte_cnt == BCW'(PKT_BYTES-1));

   // start only from idle, gpio wins
   assign pkt_take = (state == IO_IDLE) & pkt_valid & ~txi_wait & ~cfg.gpio_enable;

   //####################################################################
   // state machine and pins
   //####################################################################
   always_ff @(posedge clk) begin
      if (!nreset) begin
         state     <= IO_IDLE;
         txo_frame <= 1'b0;
         txo_data  <= 8'h00;
         byte_cnt  <= '0;
      end else begin
         case (state)
            IO_IDLE: begin
               if (cfg.gpio_enable) begin
                  state     <= IO_GPIO;
                  txo_frame <= cfg.gpio_data[8];
                  txo_data  <= cfg.gpio_data[7:0];
               end else if (pkt_take) begin
                  state     <= IO_SEND;
                  txo_frame <= 1'b1;
                  txo_data  <= pkt[7:0];          // lsb byte first
                  byte_cnt  <= '0;
               end
            end
            IO_SEND: begin
               if (last_byte) begin               // frame drops for a cycle
                  state     <= IO_IDLE;
                  txo_frame <= 1'b0;
                  txo_data  <= 8'h00;
               end else begin
                  txo_data  <= shift_reg[7:0];
                  byte_cnt  <= byte_cnt + 1'b1;
               end
            end
            IO_GPIO: begin
               if (!cfg.gpio_enable) begin
                  state     <= IO_IDLE;
                  txo_frame <= 1'b0;
                  txo_data  <= 8'h00;
               end else begin
                  txo_frame <= cfg.gpio_data[8];  // follow register
                  txo_data  <= cfg.gpio_data[7:0];
               end
            end
            default: state <= IO_IDLE;
         endcase
      end
   end

   // payload shifter
   always_ff @(posedge clk) begin
      if (pkt_take)
         shift_reg <= {8'h00, pkt[PW-1:8]};
      else if (state == IO_SEND)
         shift_reg <= {8'h00, shift_reg[PW-1:8]};
   end

   //####################################################################
   // status flags
   //####################################################################
   always_comb begin
      tx_status              = '0;
      tx_status[ST_SENT]     = (state == IO_SEND) & last_byte;
      tx_status[ST_GPIO]     = (state == IO_GPIO);
      tx_status[ST_ETX_WAIT] = etx_wait;
      tx_status[ST_TXI_WAIT] = txi_wait;
   end

endmodule

`default_nettype wire

// File: etx_top.sv
// tx link top
`timescale 1ns/1ps
`default_nettype none

module etx_top (
   input  logic                              clk,
   input  logic                              nreset,
   // register access
   input  logic                              mi_en,
   input  logic                              mi_we,
   input  logic [elink_regmap_pkg::RFAW+1:0] mi_addr,
   input  logic [31:0]                       mi_din,
   output logic [31:0]                       mi_dout,
   // parallel packet in
   input  logic                              etx_access,
   input  logic [emesh_pkg::PW-1:0]          etx_packet,
   output logic                              etx_wait,
   // pins
   input  logic                              txi_wait,
   output logic                              txo_frame,
   output logic [7:0]                        txo_data
);
   import emesh_pkg::*;

   logic          pkt_valid;
   logic [PW-1:0] pkt;
   logic          pkt_take;
   logic [15:0]   tx_status;

   etx_cfg_if u_cfg_if ();

   // register file
   etx_cfg u_cfg (
      .clk        (clk),
      .nreset     (nreset),
      .mi_en      (mi_en),
      .mi_we      (mi_we),
      .mi_addr    (mi_addr),
      .mi_din     (mi_din),
      .mi_dout    (mi_dout),
      .etx_access (etx_access),
      .etx_wait   (etx_wait),
      .etx_packet (etx_packet),
      .tx_status  (tx_status),
      .cfg        (u_cfg_if)
   );

   // holding stage
   etx_remap u_remap (
      .clk        (clk),
      .nreset     (nreset),
      .etx_access (etx_access),
      .etx_packet (etx_packet),
      .etx_wait   (etx_wait),
      .cfg        (u_cfg_if),
      .pkt_valid  (pkt_valid),
      .pkt        (pkt),
      .pkt_take   (pkt_take)
   );

   // serializer
   etx_io u_io (
      .clk        (clk),
      .nreset     (nreset),
      .cfg        (u_cfg_if),
      .pkt_valid  (pkt_valid),
      .pkt        (pkt),
      .pkt_take   (pkt_take),
      .txi_wait   (txi_wait),
      .etx_wait   (etx_wait),
      .txo_frame  (txo_frame),
      .txo_data   (txo_data),
      .tx_status  (tx_status)
   );

endmodule

`default_nettype wire

// File: etx_props.sv
// tx link assertions
`timescale 1ns/1ps
`default_nettype none

module etx_props (
   input logic clk,
   input logic nreset,
   input logic txo_frame,
   input logic etx_access,
   input logic etx_wait,
   input logic tx_enable,
   input logic gpio_enable
);

   // pins quiet while held in reset
   a_frame_reset: assert property (@(posedge clk) !nreset |=> !txo_frame)
      else $error("txo_frame high after a reset cycle");

   a_wait_disabled: assert property (@(posedge clk) disable iff (!nreset)
      !tx_enable |-> etx_wait)
      else $error("etx_wait low with tx_enable low");

   // 13 bytes then an idle cycle
   a_frame_len: assert property (@(posedge clk) disable iff (!nreset)
      $rose(txo_frame) && !gpio_enable |-> ##[1:13] !txo_frame)
      else $error("frame longer than 13 cycles");

   a_no_accept_gpio: assert property (@(posedge clk) disable iff (!nreset)
      gpio_enable |-> !(etx_access && !etx_wait))
      else $error("packet accepted in gpio mode");

endmodule

bind etx_top etx_props u_props (
   .clk         (clk),
   .nreset      (nreset),
   .txo_frame   (txo_frame),
   .etx_access  (etx_access),
   .etx_wait    (etx_wait),
   .tx_enable   (u_cfg_if.tx_enable),
   .gpio_enable (u_cfg_if.gpio_enable)
);

`default_nettype wire

// File: etx_tb.sv
// tx link testbench
`timescale 1ns/1ps
`default_nettype none

module etx_tb;
   import emesh_pkg::*;
   import elink_regmap_pkg::*;

   localparam int TIMEOUT = 200;               // cycles per wait loop

   logic            clk;
   logic            nreset;
   logic            mi_en;
   logic            mi_we;
   logic [RFAW+1:0] mi_addr;
   logic [31:0]     mi_din;
   logic [31:0]     mi_dout;
   logic            etx_access;
   logic [PW-1:0]   etx_packet;
   logic            etx_wait;
   logic            txi_wait;
   logic            txo_frame;
   logic [7:0]      txo_data;
   int              errors;
   int              tests;

   etx_top u_dut (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   //######################################################################
   // helpers
   //######################################################################
   task automatic tick();
      @(posedge clk);
      #2;                                       // inputs change off the edge
   endtask

   task automatic report_mismatch(input string name, input logic [PW-1:0] exp,
                                  input logic [PW-1:0] act);
      errors++;
      $display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, act);
   endtask

   task automatic finish_run();
      $display("tests %0d, failed checks %0d", tests, errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   endtask

   task automatic timeout_abort(input string what);
      errors++;
      $display("timeout at %0t while waiting for %s", $time, what);
      finish_run();
   endtask

   task automatic end_test(input string name, input int errs_before);
      tests++;
      if (errors == errs_before)
         $display("test %s ok", name);
      else
         $display("test %s failed, %0d errors", name, errors - errs_before);
   endtask

   task automatic mi_write(input logic [RFAW-1:0] word, input logic [31:0] data);
      mi_addr = {word, 2'b00};
      mi_din  = data;
      mi_we   = 1'b1;
      mi_en   = 1'b1;
      tick();                                   // write lands here
      mi_en   = 1'b0;
      mi_we   = 1'b0;
   endtask

   task automatic mi_read(input logic [RFAW-1:0] word, input logic [31:0] exp,
                          input string name);
      mi_addr = {word, 2'b00};
      mi_we   = 1'b0;
      mi_en   = 1'b1;
      tick();                                   // dout registered at this edge
      mi_en   = 1'b0;
      if (mi_dout !== exp)
         report_mismatch(name, exp, mi_dout);
   endtask

   // any dstaddr except the local one
   function automatic logic [31:0] remote_addr();
      logic [31:0] a;
      a = $urandom;
      if (a[31:20] == LINK_ID)
         a[31:20] = ~LINK_ID;
      return a;
   endfunction

   function automatic logic [PW-1:0] make_packet(input logic [31:0] dst);
      logic [PW-1:0] p;
      p = '0;
      p[7:0]                = 8'($urandom);     // write, datamode, ctrlmode
      p[DSTADDR_LSB +: 32]  = dst;
      p[DATA_LSB +: 32]     = $urandom;
      p[SRCADDR_LSB +: 32]  = $urandom;
      return p;
   endfunction

   // expected packet on the pins for a given config word
   function automatic logic [PW-1:0] predict(input logic [PW-1:0] p, input logic [11:0] c);
      logic [PW-1:0] q;
      logic [11:0]   hi;
      int            b;
      q = p;
      if (c[CFG_BYPASS])
         q[CTRLMODE_LSB +: 4] = c[CFG_CTRLMODE +: 4];
      if (c[CFG_REMAP +: 2] == 2'b01) begin
         hi = p[LINK_LSB +: 12];
         for (b = 0; b < 12; b++)
            if (REMAP_MASK[b])
               hi[b] = REMAP_PATTERN[b];
         q[LINK_LSB +: 12] = hi;
      end
      return q;
   endfunction

   task automatic send_packet(input logic [PW-1:0] p);
      int cnt;
      cnt        = 0;
      etx_packet = p;
      etx_access = 1'b1;
      #1;
      while (etx_wait) begin                    // held until the stage frees
         if (cnt >= TIMEOUT)
            timeout_abort("etx_wait low");
         @(posedge clk);
         #3;
         cnt++;
      end
      tick();                                   // accepted at this edge
      etx_access = 1'b0;
   endtask

   task automatic expect_packet(input logic [PW-1:0] exp);
      logic [PW-1:0] got;
      int            cnt;
      int            i;
      cnt = 0;
      got = '0;
      while (!txo_frame) begin
         if (cnt >= TIMEOUT)
            timeout_abort("txo_frame");
         tick();
         cnt++;
      end
      for (i = 0; i < PKT_BYTES; i++) begin
         if (!txo_frame) begin
            errors++;
            $display("frame dropped early at byte %0d, time %0t", i, $time);
         end
         got[i*8 +: 8] = txo_data;              // lsb byte first
         if (i < PKT_BYTES - 1)
            tick();
      end
      tick();
      if (txo_frame) begin
         errors++;
         $display("no idle cycle after 13 bytes, time %0t", $time);
      end
      if (got !== exp)
         report_mismatch("txo_data packet", exp, got);
   endtask

   //######################################################################
   // directed tests
   //######################################################################
   task automatic test_regs();
      int start;
      start = errors;
      mi_read(E_VERSION, {16'b0, DEFAULT_VERSION}, "version");
      mi_write(ETX_CFG, 32'h0000_0D5A);          // gpio field 10, stays off
      mi_read(ETX_CFG, 32'h0000_0D5A, "config");
      mi_write(ETX_GPIO, 32'hFFFF_FFFF);
      mi_read(ETX_GPIO, 32'h0000_01FF, "gpio");
      mi_write(ETX_GPIO, 32'h0000_00A5);
      mi_read(ETX_GPIO, 32'h0000_00A5, "gpio");
      mi_read(6'd6, 32'd0, "unmapped 6");
      mi_read(6'd63, 32'd0, "unmapped 63");
      mi_write(ETX_CFG, 32'd0);
      mi_write(ETX_GPIO, 32'd0);
      end_test("register access", start);
   endtask

   task automatic test_plain();
      logic [PW-1:0] p1;
      logic [PW-1:0] p2;
      int            start;
      start = errors;
      p1 = make_packet(remote_addr());
      p2 = make_packet(remote_addr());
      mi_write(ETX_CFG, 32'(1 << CFG_TX_ENABLE));
      send_packet(p1);
      send_packet(p2);                          // back to back
      expect_packet(p1);
      expect_packet(p2);
      end_test("plain transfer", start);
   endtask

   task automatic test_remap();
      logic [11:0]   c;
      logic [PW-1:0] p;
      int            start;
      start = errors;
      c = 12'((1 << CFG_TX_ENABLE) | (1 << CFG_REMAP) | (9 << CFG_CTRLMODE) |
              (1 << CFG_BYPASS));
      mi_write(ETX_CFG, {20'b0, c});
      p = make_packet(remote_addr());
      send_packet(p);
      expect_packet(predict(p, c));
      end_test("override and remap", start);
   endtask

   task automatic test_monitor();
      logic [11:0]   c;
      logic [PW-1:0] p;
      logic [31:0]   dst;
      int            k;
      int            start;
      start = errors;
      c = 12'((1 << CFG_TX_ENABLE) | (1 << CFG_REMAP));  // remap on, sample is pre-remap
      mi_write(ETX_CFG, {20'b0, c});
      mi_write(ETX_MONITOR, 32'd0);
      dst = '0;
      for (k = 0; k < 3; k++) begin
         dst = remote_addr();
         p   = make_packet(dst);
         send_packet(p);
         expect_packet(predict(p, c));
      end
      p = make_packet({LINK_ID, 20'($urandom)});        // local, not counted
      send_packet(p);
      expect_packet(predict(p, c));
      mi_read(ETX_MONITOR, 32'd3, "monitor");
      mi_read(ETX_PACKET, dst, "packet sample");
      mi_write(ETX_MONITOR, 32'h0000_0055);
      mi_read(ETX_MONITOR, 32'h0000_0055, "monitor reload");
      end_test("monitor and sampler", start);
   endtask

   task automatic test_gpio();
      logic [15:0]   st;
      logic [PW-1:0] p;
      int            start;
      start = errors;
      st = 16'((1 << ST_GPIO) | (1 << ST_ETX_WAIT));
      mi_write(ETX_GPIO, 32'h0000_01C3);
      mi_write(ETX_STATUS, 32'd0);
      mi_write(ETX_CFG, 32'((1 << CFG_TX_ENABLE) | (1 << CFG_GPIO)));
      tick();                                   // pins follow one cycle later
      if (txo_frame !== 1'b1)
         report_mismatch("txo_frame", 1, txo_frame);
      if (txo_data !== 8'hC3)
         report_mismatch("txo_data", 8'hC3, txo_data);
      if (etx_wait !== 1'b1)
         report_mismatch("etx_wait", 1, etx_wait);
      mi_write(ETX_CFG, 32'(1 << CFG_TX_ENABLE));
      tick();
      if (txo_frame !== 1'b0)
         report_mismatch("txo_frame", 0, txo_frame);
      mi_read(ETX_STATUS, {16'b0, st}, "status sticky");
      p = make_packet(remote_addr());
      send_packet(p);
      expect_packet(p);
      mi_read(ETX_STATUS, {16'b0, st | 16'(1 << ST_SENT)}, "status sent");
      mi_write(ETX_STATUS, 32'd0);
      mi_read(ETX_STATUS, 32'd0, "status cleared");
      end_test("gpio and status", start);
   endtask

   task automatic test_backpressure();
      logic [PW-1:0] p;
      int            i;
      int            start;
      start = errors;
      p = make_packet(remote_addr());
      mi_write(ETX_CFG, 32'(1 << CFG_TX_ENABLE));
      txi_wait = 1'b1;
      send_packet(p);
      if (etx_wait !== 1'b1)
         report_mismatch("etx_wait", 1, etx_wait);   // one packet held
      for (i = 0; i < 6; i++) begin
         if (txo_frame !== 1'b0)
            report_mismatch("txo_frame", 0, txo_frame);
         tick();
      end
      txi_wait = 1'b0;
      expect_packet(p);
      end_test("back-pressure", start);
   endtask

   //######################################################################
   // main sequence
   //######################################################################
   initial begin
      void'($urandom(24));
      errors     = 0;
      tests      = 0;
      nreset     = 1'b0;
      mi_en      = 1'b0;
      mi_we      = 1'b0;
      mi_addr    = '0;
      mi_din     = '0;
      etx_access = 1'b0;
      etx_packet = '0;
      txi_wait   = 1'b0;
      repeat (4) @(posedge clk);
      #2 nreset = 1'b1;
      tick();
      test_regs();
      test_plain();
      test_remap();
      test_monitor();
      test_gpio();
      test_backpressure();
      finish_run();
   end

endmodule

`default_nettype wire

// File: etx.f
emesh_pkg.sv
elink_regmap_pkg.sv
etx_cfg_if.sv
etx_cfg.sv
etx_remap.sv
etx_io.sv
etx_top.sv
etx_props.sv
etx_tb.sv

// File: Makefile
# Verilator flow for the tx link

VERILATOR ?= verilator
TOP       ?= etx_tb
FILELIST  ?= etx.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q -F '*** PASSED ***' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
